// ==== bench/skdecode_tb.sv ====
// --------------------------------------------------------------------------
// Secret key decode testbench
// Models key and coefficient memory, drives LCG keys into the DUT and
// checks every written coefficient against a reference model
// --------------------------------------------------------------------------
`include "skdecode_defs.svh"

module skdecode_tb;

    localparam int MEM_WORDS = 1 << `SKD_ADDR_W;
    localparam int SS_KEYS   = `SKD_S1_KEY_WORDS + `SKD_S2_KEY_WORDS;
    localparam int KEY_TOTAL = SS_KEYS + `SKD_T0_KEY_WORDS;
    localparam int WR_TOTAL  = `SKD_S1_WR_WORDS + `SKD_S2_WR_WORDS + `SKD_T0_WR_WORDS;
    localparam int TIMEOUT   = 4000;

    logic                   clk;
    logic                   reset_n;
    logic                   zeroize;
    logic                   start;
    logic [`SKD_ADDR_W-1:0] src_base_addr;
    logic [`SKD_ADDR_W-1:0] dest_base_addr;
    logic [`SKD_KEY_W-1:0]  key_rd_data;
    skdecode_pkg::mem_req_t key_rd_req;
    skdecode_pkg::coef_wr_t coef_wr_req;
    logic                   skdecode_done;
    logic                   s1_done;
    logic                   s2_done;
    logic                   t0_done;
    logic                   error;

    logic [`SKD_KEY_W-1:0]    key_mem [0:MEM_WORDS-1];
    skdecode_pkg::coef_word_t coef_mem [0:MEM_WORDS-1];
    logic [31:0]              lcg_state;
    int reads;
    int writes;
    int reads_outside;
    int writes_outside;
    int checks;
    int errors;
    int tests;
    int tests_failed;

    skdecode_top u_skdecode_top (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .start          (start),
        .src_base_addr  (src_base_addr),
        .dest_base_addr (dest_base_addr),
        .key_rd_data    (key_rd_data),
        .key_rd_req     (key_rd_req),
        .coef_wr_req    (coef_wr_req),
        .skdecode_done  (skdecode_done),
        .s1_done        (s1_done),
        .s2_done        (s2_done),
        .t0_done        (t0_done),
        .error          (error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------------------------------
    // Memory models
    // --------------------------------------------------------------------------
    // Key memory returns data one cycle after the read
    always @(posedge clk) begin
        if (key_rd_req.rd_wr_en == skdecode_pkg::RW_READ) begin
            key_rd_data <= key_mem[key_rd_req.addr];
            reads       <= reads + 1;
            if (key_rd_req.addr < src_base_addr || key_rd_req.addr >= src_base_addr + KEY_TOTAL)
                reads_outside <= reads_outside + 1;
        end
    end

    always @(posedge clk) begin
        if (coef_wr_req.rd_wr_en == skdecode_pkg::RW_WRITE) begin
            coef_mem[coef_wr_req.addr] <= coef_wr_req.data;
            writes <= writes + 1;
            if (coef_wr_req.addr < dest_base_addr ||
                coef_wr_req.addr >= dest_base_addr + WR_TOTAL)
                writes_outside <= writes_outside + 1;
        end
    end

    // --------------------------------------------------------------------------
    // Stimulus and reference model
    // --------------------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // eta minus field reduced mod q
    function automatic skdecode_pkg::coef_word_t model_s1s2(input logic [63:0] kw, input int half);
        skdecode_pkg::coef_word_t w;
        int v;
        for (int i = 0; i < 4; i++) begin
            v = `SKD_ETA - int'(kw[(4*half+i)*`SKD_S1S2_FIELD_W +: `SKD_S1S2_FIELD_W]);
            if (v < 0)
                v = v + `SKD_Q;
            w.coef[i] = v[`SKD_COEF_W-1:0];
        end
        return w;
    endfunction

    // 4096 minus field reduced mod q
    function automatic skdecode_pkg::coef_word_t model_t0(input logic [63:0] kw);
        skdecode_pkg::coef_word_t w;
        int v;
        for (int i = 0; i < 4; i++) begin
            v = `SKD_T0_HALF - int'(kw[i*`SKD_T0_FIELD_W +: `SKD_T0_FIELD_W]);
            if (v < 0)
                v = v + `SKD_Q;
            w.coef[i] = v[`SKD_COEF_W-1:0];
        end
        return w;
    endfunction

    // New bases, fresh keys and an address-tagged fill of the coefficients
    task automatic prepare_decode(input logic [`SKD_ADDR_W-1:0] src,
                                  input logic [`SKD_ADDR_W-1:0] dest);
        logic [63:0] kw;
        src_base_addr  = src;
        dest_base_addr = dest;
        for (int a = 0; a < MEM_WORDS; a++) begin
            key_mem[a]  = {next_rand(), next_rand()};
            coef_mem[a] = {4{10'h2a5, a[13:0]}};
        end
        for (int i = 0; i < SS_KEYS; i++) begin
            kw = key_mem[src + i];
            for (int f = 0; f < 8; f++)
                kw[f*`SKD_S1S2_FIELD_W +: `SKD_S1S2_FIELD_W] = 3'(next_rand() % 5);
            key_mem[src + i] = kw;
        end
        reads          = 0;
        writes         = 0;
        reads_outside  = 0;
        writes_outside = 0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    // --------------------------------------------------------------------------
    // Checks
    // --------------------------------------------------------------------------
    task automatic check_value(input logic [95:0] actual, input logic [95:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s: got %0h expected %0h", $time, msg, actual, expected);
        end
    endtask

    task automatic check_idle(input string tag);
        check_value(key_rd_req.rd_wr_en, skdecode_pkg::RW_IDLE, {tag, " key read mode"});
        check_value(coef_wr_req.rd_wr_en, skdecode_pkg::RW_IDLE, {tag, " write mode"});
        check_value(skdecode_done, 1'b1, {tag, " done"});
        check_value({s1_done, s2_done, t0_done, error}, 4'b0000, {tag, " flags and error"});
    endtask

    // Samples the section flags every cycle until done
    task automatic wait_decode(input string tag);
        int cycles;
        int s1_at;
        int s2_at;
        int t0_at;
        cycles = 0;
        s1_at  = -1;
        s2_at  = -1;
        t0_at  = -1;
        while (!skdecode_done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (s1_done && s1_at < 0) begin
                s1_at = cycles;
                check_value(writes, `SKD_S1_WR_WORDS, {tag, " writes at s1_done"});
            end
            if (s2_done && s2_at < 0) begin
                s2_at = cycles;
                check_value(writes, `SKD_S1_WR_WORDS + `SKD_S2_WR_WORDS,
                            {tag, " writes at s2_done"});
            end
            if (t0_done && t0_at < 0) begin
                t0_at = cycles;
                check_value(writes, WR_TOTAL, {tag, " writes at t0_done"});
            end
        end
        if (!skdecode_done) begin
            $display("Timeout: %s did not finish within %0d cycles", tag, TIMEOUT);
            $display("FAIL: see errors above");
            $finish;
        end else begin
            check_value(s1_at > 0 && s2_at > s1_at && t0_at > s2_at, 1'b1,
                        {tag, " section flag order"});
        end
    endtask

    task automatic check_decode(input string tag);
        logic [63:0] kw;
        for (int i = 0; i < SS_KEYS; i++) begin
            kw = key_mem[src_base_addr + i];
            check_value(coef_mem[dest_base_addr + 2*i], model_s1s2(kw, 0),
                        $sformatf("%s s1/s2 word %0d", tag, 2*i));
            check_value(coef_mem[dest_base_addr + 2*i + 1], model_s1s2(kw, 1),
                        $sformatf("%s s1/s2 word %0d", tag, 2*i + 1));
        end
        for (int i = 0; i < `SKD_T0_KEY_WORDS; i++) begin
            kw = key_mem[src_base_addr + SS_KEYS + i];
            check_value(coef_mem[dest_base_addr + 2*SS_KEYS + i], model_t0(kw),
                        $sformatf("%s t0 word %0d", tag, i));
        end
        check_value(reads, KEY_TOTAL, {tag, " key reads"});
        check_value(writes, WR_TOTAL, {tag, " coefficient writes"});
        check_value(reads_outside, 0, {tag, " reads outside source range"});
        check_value(writes_outside, 0, {tag, " writes outside destination range"});
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests, name, errors - errors_before);
        end
    endtask

    task automatic run_decode(input string tag, input logic [`SKD_ADDR_W-1:0] src,
                              input logic [`SKD_ADDR_W-1:0] dest);
        prepare_decode(src, dest);
        pulse_start();
        wait_decode(tag);
        repeat (4) @(posedge clk);
        #1;
    endtask

    // --------------------------------------------------------------------------
    // Test sequence
    // --------------------------------------------------------------------------
    initial begin
        int err0;
        int bad_word;
        int bad_idx;
        int bad_value;
        int cycles;
        lcg_state      = 32'h52fba1a4;
        checks         = 0;
        errors         = 0;
        tests          = 0;
        tests_failed   = 0;
        reset_n        = 1'b0;
        zeroize        = 1'b0;
        start          = 1'b0;
        src_base_addr  = '0;
        dest_base_addr = '0;
        key_rd_data    = '0;
        repeat (16) @(posedge clk);
        #1 reset_n = 1'b1;
        @(posedge clk);
        #1;

        err0 = errors;
        check_idle("reset");
        end_test("idle after reset", err0);

        err0 = errors;
        run_decode("base zero", 14'h0000, 14'h0000);
        check_decode("base zero");
        check_value(error, 1'b0, "base zero error flag");
        end_test("full decode at base zero", err0);

        err0 = errors;
        run_decode("offset", 14'h0a37, 14'h1c05);
        check_decode("offset");
        check_value(error, 1'b0, "offset error flag");
        end_test("decode with offset bases", err0);

        // One s1/s2 field forced to 5, 6 or 7
        err0 = errors;
        prepare_decode(14'h0150, 14'h2400);
        bad_word  = next_rand() % SS_KEYS;
        bad_idx   = next_rand() % 8;
        bad_value = 5 + next_rand() % 3;
        key_mem[src_base_addr + bad_word][bad_idx*`SKD_S1S2_FIELD_W +: `SKD_S1S2_FIELD_W] =
            3'(bad_value);
        pulse_start();
        wait_decode("bad field");
        repeat (4) @(posedge clk);
        #1;
        check_decode("bad field");
        check_value(coef_mem[dest_base_addr + 2*bad_word + bad_idx/4].coef[bad_idx%4],
                    `SKD_Q + `SKD_ETA - bad_value, "bad field coefficient");
        check_value(error, 1'b1, "bad field error flag");
        end_test("invalid eta field", err0);

        // Start of a clean decode clears the error left by the previous one
        err0 = errors;
        run_decode("flag order", 14'h1000, 14'h0c00);
        check_value({s1_done, s2_done, t0_done}, 3'b111, "flags after done");
        check_value(error, 1'b0, "flag order error flag");
        end_test("section flag order", err0);

        // Zeroize partway through s2 and follow with a clean decode
        err0 = errors;
        prepare_decode(14'h0800, 14'h3000);
        // A bad field in the first s1 word raises error before the zeroize
        key_mem[src_base_addr][`SKD_S1S2_FIELD_W-1:0] = 3'd7;
        pulse_start();
        cycles = 0;
        while (!s1_done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!s1_done) begin
            $display("Timeout: s1 section never finished before zeroize");
            $display("FAIL: see errors above");
            $finish;
        end
        repeat (20) @(posedge clk);
        #1 zeroize = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        check_idle("zeroize");
        zeroize = 1'b0;
        @(posedge clk);
        #1;
        check_idle("after zeroize");
        run_decode("after zeroize", 14'h0040, 14'h0400);
        check_decode("after zeroize");
        check_value(error, 1'b0, "after zeroize error flag");
        end_test("zeroize mid decode", err0);

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests, tests_failed, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== source/skdecode_ctrl.sv ====
// --------------------------------------------------------------------------
// Secret key decode control
// Paces key reads per section, steers the unpackers and tracks the
// coefficient writes until all three sections are complete
// --------------------------------------------------------------------------
`include "skdecode_defs.svh"

module skdecode_ctrl (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    input  logic                       start,
    input  logic [`SKD_ADDR_W-1:0]     src_base_addr,
    input  logic [`SKD_ADDR_W-1:0]     dest_base_addr,
    input  logic                       s1s2_valid,
    input  logic                       t0_valid,
    output skdecode_pkg::mem_req_t     key_rd_req,
    output logic                       s1s2_enable,
    output logic                       t0_enable,
    output logic [`SKD_ADDR_W-1:0]     wr_addr,
    output skdecode_pkg::mem_rw_mode_e wr_en,
    output logic                       s1_done,
    output logic                       s2_done,
    output logic                       t0_done,
    output logic                       skdecode_done
);

    skdecode_pkg::skdec_read_state_e  rd_state, rd_state_nxt;
    skdecode_pkg::skdec_write_state_e wr_state, wr_state_nxt;

    logic [`SKD_ADDR_W-1:0] rd_addr;
    logic [`SKD_ADDR_W-1:0] rd_count;
    logic [`SKD_ADDR_W-1:0] rd_total;
    logic [`SKD_ADDR_W-1:0] wr_count;
    logic [`SKD_ADDR_W-1:0] wr_total;
    logic [`SKD_ADDR_W-1:0] wr_addr_base_q;
    logic                   pace;
    logic                   rd_issue;
    logic                   start_ok;
    logic                   wr_valid;
    logic                   wr_sec_end;

    assign skdecode_done = (wr_state == skdecode_pkg::SKDEC_WR_IDLE);
    assign start_ok      = start & skdecode_done;

    // --------------------------------------------------------------------------
    // Read side
    // --------------------------------------------------------------------------
    always_comb begin
        rd_total = '0;
        case (rd_state)
            skdecode_pkg::SKDEC_RD_S1: rd_total = `SKD_S1_KEY_WORDS;
            skdecode_pkg::SKDEC_RD_S2: rd_total = `SKD_S2_KEY_WORDS;
            skdecode_pkg::SKDEC_RD_T0: rd_total = `SKD_T0_KEY_WORDS;
            default:                   rd_total = '0;
        endcase
    end

    // s1/s2 words give two write words each, so read on alternate cycles.
    // A section ends on a pace cycle, leaving the write side time to stage.
    always_comb begin
        rd_state_nxt = rd_state;
        rd_issue     = 1'b0;
        unique case (rd_state)
            skdecode_pkg::SKDEC_RD_IDLE: begin
                if (start_ok)
                    rd_state_nxt = skdecode_pkg::SKDEC_RD_S1;
            end
            skdecode_pkg::SKDEC_RD_S1,
            skdecode_pkg::SKDEC_RD_S2: begin
                rd_issue = pace & (rd_count != rd_total);
                if ((rd_count == rd_total) && pace)
                    rd_state_nxt = (rd_state == skdecode_pkg::SKDEC_RD_S1) ?
                                   skdecode_pkg::SKDEC_RD_S2 : skdecode_pkg::SKDEC_RD_T0;
            end
            skdecode_pkg::SKDEC_RD_T0: begin
                rd_issue = (rd_count != rd_total);
                if ((rd_count == rd_total) && pace)
                    rd_state_nxt = skdecode_pkg::SKDEC_RD_IDLE;
            end
            default: rd_state_nxt = skdecode_pkg::SKDEC_RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state    <= skdecode_pkg::SKDEC_RD_IDLE;
            rd_addr     <= '0;
            rd_count    <= '0;
            pace        <= 1'b0;
            s1s2_enable <= 1'b0;
            t0_enable   <= 1'b0;
        end else if (zeroize) begin
            rd_state    <= skdecode_pkg::SKDEC_RD_IDLE;
            rd_addr     <= '0;
            rd_count    <= '0;
            pace        <= 1'b0;
            s1s2_enable <= 1'b0;
            t0_enable   <= 1'b0;
        end else begin
            rd_state    <= rd_state_nxt;
            pace        <= ~pace;
            s1s2_enable <= rd_issue & (rd_state != skdecode_pkg::SKDEC_RD_T0);
            t0_enable   <= rd_issue & (rd_state == skdecode_pkg::SKDEC_RD_T0);
            if (start_ok) begin
                rd_addr  <= src_base_addr;
                rd_count <= '0;
                pace     <= 1'b1;
            end else if (rd_state_nxt != rd_state) begin
                rd_count <= '0;
            end else if (rd_issue) begin
                rd_addr  <= rd_addr + 1'b1;
                rd_count <= rd_count + 1'b1;
            end
        end
    end

    assign key_rd_req.addr     = rd_addr;
    assign key_rd_req.rd_wr_en = rd_issue ? skdecode_pkg::RW_READ : skdecode_pkg::RW_IDLE;

    // --------------------------------------------------------------------------
    // Write side lagging the read side
    // --------------------------------------------------------------------------
    always_comb begin
        wr_valid = 1'b0;
        wr_total = '0;
        case (wr_state)
            skdecode_pkg::SKDEC_WR_S1: begin
                wr_valid = s1s2_valid;
                wr_total = `SKD_S1_WR_WORDS;
            end
            skdecode_pkg::SKDEC_WR_S2: begin
                wr_valid = s1s2_valid;
                wr_total = `SKD_S2_WR_WORDS;
            end
            skdecode_pkg::SKDEC_WR_T0: begin
                wr_valid = t0_valid;
                wr_total = `SKD_T0_WR_WORDS;
            end
            default: ;
        endcase
    end

    assign wr_sec_end = wr_valid & (wr_count == wr_total - 1'b1);
    assign wr_addr    = wr_count + wr_addr_base_q;
    assign wr_en      = wr_valid ? skdecode_pkg::RW_WRITE : skdecode_pkg::RW_IDLE;

    // Stage picks the next section from the flags it has not yet raised
    always_comb begin
        wr_state_nxt = wr_state;
        unique case (wr_state)
            skdecode_pkg::SKDEC_WR_IDLE:
                if (start_ok)
                    wr_state_nxt = skdecode_pkg::SKDEC_WR_S1;
            skdecode_pkg::SKDEC_WR_S1,
            skdecode_pkg::SKDEC_WR_S2,
            skdecode_pkg::SKDEC_WR_T0:
                if (wr_sec_end)
                    wr_state_nxt = skdecode_pkg::SKDEC_WR_STAGE;
            skdecode_pkg::SKDEC_WR_STAGE:
                wr_state_nxt = !s1_done ? skdecode_pkg::SKDEC_WR_S2 :
                               !s2_done ? skdecode_pkg::SKDEC_WR_T0 :
                                          skdecode_pkg::SKDEC_WR_IDLE;
            default: wr_state_nxt = skdecode_pkg::SKDEC_WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_state       <= skdecode_pkg::SKDEC_WR_IDLE;
            wr_addr_base_q <= '0;
            wr_count       <= '0;
            {s1_done, s2_done, t0_done} <= 3'b000;
        end else if (zeroize) begin
            wr_state       <= skdecode_pkg::SKDEC_WR_IDLE;
            wr_addr_base_q <= '0;
            wr_count       <= '0;
            {s1_done, s2_done, t0_done} <= 3'b000;
        end else begin
            wr_state <= wr_state_nxt;
            if (start_ok) begin
                wr_addr_base_q <= dest_base_addr;
                wr_count       <= '0;
                {s1_done, s2_done, t0_done} <= 3'b000;
            end else if (wr_sec_end) begin
                // Addresses run on across sections
                wr_addr_base_q <= wr_addr + 1'b1;
                wr_count       <= '0;
            end else if (wr_valid) begin
                wr_count <= wr_count + 1'b1;
            end
            if (wr_state == skdecode_pkg::SKDEC_WR_STAGE) begin
                if (!s1_done)
                    s1_done <= 1'b1;
                else if (!s2_done)
                    s2_done <= 1'b1;
                else
                    t0_done <= 1'b1;
            end
        end
    end

endmodule

// ==== source/skdecode_defs.svh ====
// --------------------------------------------------------------------------
// Secret key decode sizes
// Ring and modulus constants, field widths and per-section word counts
// --------------------------------------------------------------------------
`ifndef SKDECODE_DEFS_SVH
`define SKDECODE_DEFS_SVH

`define SKD_L             4
`define SKD_K             4
`define SKD_N             256
`define SKD_Q             8380417
`define SKD_ADDR_W        14
`define SKD_KEY_W         64
`define SKD_COEF_W        24
`define SKD_S1S2_FIELD_W  3
`define SKD_T0_FIELD_W    13
`define SKD_ETA           2
`define SKD_T0_HALF       4096

// Section lengths in key words and in write words
`define SKD_S1_KEY_WORDS  (`SKD_L * `SKD_N / 8)
`define SKD_S1_WR_WORDS   (`SKD_L * `SKD_N / 4)
`define SKD_S2_KEY_WORDS  (`SKD_K * `SKD_N / 8)
`define SKD_S2_WR_WORDS   (`SKD_K * `SKD_N / 4)
`define SKD_T0_KEY_WORDS  (`SKD_K * `SKD_N / 4)
`define SKD_T0_WR_WORDS   (`SKD_K * `SKD_N / 4)

`endif

// ==== source/skdecode_pkg.sv ====
// --------------------------------------------------------------------------
// Secret key decode types
// Memory request formats, coefficient words and the FSM state encodings
// --------------------------------------------------------------------------
`include "skdecode_defs.svh"

package skdecode_pkg;

    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } mem_rw_mode_e;

    // Key memory read request
    typedef struct packed {
        logic [`SKD_ADDR_W-1:0] addr;
        mem_rw_mode_e           rd_wr_en;
    } mem_req_t;

    typedef logic [`SKD_COEF_W-1:0] coef_t;

    // Four consecutive coefficients, lane 0 is the lowest index
    typedef struct packed {
        coef_t [3:0] coef;
    } coef_word_t;

    // Coefficient memory write request
    typedef struct packed {
        logic [`SKD_ADDR_W-1:0] addr;
        mem_rw_mode_e           rd_wr_en;
        coef_word_t             data;
    } coef_wr_t;

    typedef enum logic [1:0] {
        SKDEC_RD_IDLE,
        SKDEC_RD_S1,
        SKDEC_RD_S2,
        SKDEC_RD_T0
    } skdec_read_state_e;

    typedef enum logic [2:0] {
        SKDEC_WR_IDLE,
        SKDEC_WR_S1,
        SKDEC_WR_S2,
        SKDEC_WR_T0,
        SKDEC_WR_STAGE
    } skdec_write_state_e;

endpackage

// ==== source/skdecode_result.sv ====
// --------------------------------------------------------------------------
// Secret key decode result stage
// Registers the coefficient write request and keeps the sticky eta error
// --------------------------------------------------------------------------
`include "skdecode_defs.svh"

module skdecode_result (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize,
    input  logic                       start,
    input  logic [`SKD_ADDR_W-1:0]     wr_addr,
    input  skdecode_pkg::mem_rw_mode_e wr_en,
    input  logic                       s1s2_valid,
    input  skdecode_pkg::coef_word_t   s1s2_data,
    input  logic                       t0_valid,
    input  skdecode_pkg::coef_word_t   t0_data,
    input  logic                       s1s2_error,
    output skdecode_pkg::coef_wr_t     coef_wr_req,
    output logic                       error
);

    logic [`SKD_ADDR_W-1:0]     addr_q;
    skdecode_pkg::mem_rw_mode_e mode_q;
    skdecode_pkg::coef_word_t   data_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            addr_q <= '0;
            mode_q <= skdecode_pkg::RW_IDLE;
            error  <= 1'b0;
        end else if (zeroize) begin
            addr_q <= '0;
            mode_q <= skdecode_pkg::RW_IDLE;
            error  <= 1'b0;
        end else begin
            addr_q <= wr_addr;
            mode_q <= wr_en;
            // Bad fields are flagged, decoding carries on
            if (start)
                error <= 1'b0;
            else if (s1s2_error)
                error <= 1'b1;
        end
    end

    // Only one unpacker is valid in a given cycle
    always_ff @(posedge clk) begin
        if (t0_valid)
            data_q <= t0_data;
        else if (s1s2_valid)
            data_q <= s1s2_data;
    end

    assign coef_wr_req.addr     = addr_q;
    assign coef_wr_req.rd_wr_en = mode_q;
    assign coef_wr_req.data     = data_q;

endmodule

// ==== source/skdecode_s1s2_unpack.sv ====
// --------------------------------------------------------------------------
// s1/s2 unpacker for eta = 2
// Turns eight 3-bit fields of a key word into two coefficient words
// and strobes an error for fields outside 0 to 4
// --------------------------------------------------------------------------
`include "skdecode_defs.svh"

module skdecode_s1s2_unpack (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    input  logic                     enable,
    input  logic [`SKD_KEY_W-1:0]    key_rd_data,
    output logic                     s1s2_valid,
    output skdecode_pkg::coef_word_t s1s2_data,
    output logic                     s1s2_error
);

    logic [4*`SKD_S1S2_FIELD_W-1:0] upper_fields;
    logic                           upper_pending;
    skdecode_pkg::coef_word_t       lower_word;
    skdecode_pkg::coef_word_t       upper_word;
    logic                           lower_bad;
    logic                           upper_bad;

    // eta minus field, mod q
    function automatic skdecode_pkg::coef_t eta_to_coef(
        input logic [`SKD_S1S2_FIELD_W-1:0] field
    );
        if (field <= `SKD_ETA)
            return skdecode_pkg::coef_t'(`SKD_ETA - field);
        return skdecode_pkg::coef_t'(`SKD_Q + `SKD_ETA - field);
    endfunction

    always_comb begin
        lower_bad = 1'b0;
        upper_bad = 1'b0;
        for (int i = 0; i < 4; i++) begin
            lower_word.coef[i] = eta_to_coef(key_rd_data[i*`SKD_S1S2_FIELD_W +: `SKD_S1S2_FIELD_W]);
            upper_word.coef[i] = eta_to_coef(upper_fields[i*`SKD_S1S2_FIELD_W +: `SKD_S1S2_FIELD_W]);
            lower_bad |= (key_rd_data[i*`SKD_S1S2_FIELD_W +: `SKD_S1S2_FIELD_W] > 2*`SKD_ETA);
            upper_bad |= (upper_fields[i*`SKD_S1S2_FIELD_W +: `SKD_S1S2_FIELD_W] > 2*`SKD_ETA);
        end
    end

    // Fields 0-3 the cycle after enable, fields 4-7 the cycle after that
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1s2_valid    <= 1'b0;
            s1s2_error    <= 1'b0;
            upper_pending <= 1'b0;
        end else if (zeroize) begin
            s1s2_valid    <= 1'b0;
            s1s2_error    <= 1'b0;
            upper_pending <= 1'b0;
        end else begin
            s1s2_valid    <= enable | upper_pending;
            s1s2_error    <= enable ? lower_bad : (upper_pending & upper_bad);
            upper_pending <= enable;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            upper_fields <= key_rd_data[8*`SKD_S1S2_FIELD_W-1:4*`SKD_S1S2_FIELD_W];
            s1s2_data    <= lower_word;
        end else if (upper_pending) begin
            s1s2_data <= upper_word;
        end
    end

endmodule

// ==== source/skdecode_t0_unpack.sv ====
// --------------------------------------------------------------------------
// t0 unpacker
// Splits a key word into four 13-bit fields, one coefficient word out
// --------------------------------------------------------------------------
`include "skdecode_defs.svh"

module skdecode_t0_unpack (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    input  logic                     enable,
    input  logic [`SKD_KEY_W-1:0]    key_rd_data,
    output logic                     t0_valid,
    output skdecode_pkg::coef_word_t t0_data
);

    skdecode_pkg::coef_word_t t0_word;

    // 2^12 minus field, mod q
    function automatic skdecode_pkg::coef_t t0_to_coef(
        input logic [`SKD_T0_FIELD_W-1:0] field
    );
        if (field <= `SKD_T0_HALF)
            return skdecode_pkg::coef_t'(`SKD_T0_HALF - field);
        return skdecode_pkg::coef_t'(`SKD_Q + `SKD_T0_HALF - field);
    endfunction

    always_comb begin
        for (int i = 0; i < 4; i++)
            t0_word.coef[i] = t0_to_coef(key_rd_data[i*`SKD_T0_FIELD_W +: `SKD_T0_FIELD_W]);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            t0_valid <= 1'b0;
        else if (zeroize)
            t0_valid <= 1'b0;
        else
            t0_valid <= enable;
    end

    always_ff @(posedge clk) begin
        if (enable)
            t0_data <= t0_word;
    end

endmodule

// ==== source/skdecode_top.sv ====
// --------------------------------------------------------------------------
// Secret key decode subsystem
// Decodes the s1, s2 and t0 sections of a packed key into coefficients
// --------------------------------------------------------------------------
`include "skdecode_defs.svh"

module skdecode_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize,
    input  logic                   start,
    input  logic [`SKD_ADDR_W-1:0] src_base_addr,
    input  logic [`SKD_ADDR_W-1:0] dest_base_addr,
    input  logic [`SKD_KEY_W-1:0]  key_rd_data,
    output skdecode_pkg::mem_req_t key_rd_req,
    output skdecode_pkg::coef_wr_t coef_wr_req,
    output logic                   skdecode_done,
    output logic                   s1_done,
    output logic                   s2_done,
    output logic                   t0_done,
    output logic                   error
);

    logic                       s1s2_enable;
    logic                       t0_enable;
    logic                       s1s2_valid;
    logic                       t0_valid;
    logic                       s1s2_error;
    skdecode_pkg::coef_word_t   s1s2_data;
    skdecode_pkg::coef_word_t   t0_data;
    logic [`SKD_ADDR_W-1:0]     wr_addr;
    skdecode_pkg::mem_rw_mode_e wr_en;

    // Decode
    skdecode_ctrl u_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .start          (start),
        .src_base_addr  (src_base_addr),
        .dest_base_addr (dest_base_addr),
        .s1s2_valid     (s1s2_valid),
        .t0_valid       (t0_valid),
        .key_rd_req     (key_rd_req),
        .s1s2_enable    (s1s2_enable),
        .t0_enable      (t0_enable),
        .wr_addr        (wr_addr),
        .wr_en          (wr_en),
        .s1_done        (s1_done),
        .s2_done        (s2_done),
        .t0_done        (t0_done),
        .skdecode_done  (skdecode_done)
    );

    // Execute
    skdecode_s1s2_unpack u_s1s2_unpack (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .enable      (s1s2_enable),
        .key_rd_data (key_rd_data),
        .s1s2_valid  (s1s2_valid),
        .s1s2_data   (s1s2_data),
        .s1s2_error  (s1s2_error)
    );

    skdecode_t0_unpack u_t0_unpack (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .enable      (t0_enable),
        .key_rd_data (key_rd_data),
        .t0_valid    (t0_valid),
        .t0_data     (t0_data)
    );

    // Result
    skdecode_result u_result (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .start       (start),
        .wr_addr     (wr_addr),
        .wr_en       (wr_en),
        .s1s2_valid  (s1s2_valid),
        .s1s2_data   (s1s2_data),
        .t0_valid    (t0_valid),
        .t0_data     (t0_data),
        .s1s2_error  (s1s2_error),
        .coef_wr_req (coef_wr_req),
        .error       (error)
    );

endmodule

// ==== src.f ====
+incdir+source
source/skdecode_pkg.sv
source/skdecode_ctrl.sv
source/skdecode_s1s2_unpack.sv
source/skdecode_t0_unpack.sv
source/skdecode_result.sv
source/skdecode_top.sv
bench/skdecode_tb.sv
